// File: pixel_shader.f
+incdir+include
verilog/geom_pkg.sv
verilog/shade_pkg.sv
verilog/normal_pipeline.sv
verilog/normal_fifo.sv
verilog/shade_lookup.sv
verilog/pixel_shader.sv
verif/pixel_shader_tb.sv

// File: Bender.yml
package:
  name: pixel_shader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/geom_pkg.sv
      - verilog/shade_pkg.sv
      - verilog/normal_pipeline.sv
      - verilog/normal_fifo.sv
      - verilog/shade_lookup.sv
      - verilog/pixel_shader.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/pixel_shader_tb.sv

// File: verif/pixel_shader_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "shader_settings.svh"

module pixel_shader_tb;
    import geom_pkg::*;
    import shade_pkg::*;

    logic    clk_in;
    logic    rst_in;
    logic    tri_valid_in;
    vertex_t v0_in;
    vertex_t v1_in;
    vertex_t v2_in;
    logic    color_valid_out;
    color_t  color_out;
    logic    overflow_out;

    // expected colors in acceptance order, with the id of each triangle
    color_t      exp_q[$];
    int          id_q[$];
    color_t      exp_head;
    int          exp_count;
    int          cur_id;
    int          next_id;
    // accepted triangles of the last 4 edges, newest in slot 0
    logic [3:0]  acc_hist;
    int          acc_id [4];
    // color strobe sampled at the last edge
    logic        color_taken;
    int          errors;
    int          colors_rx;
    int          ovf_seen;
    logic        quiet_chk;
    logic        no_ovf_chk;
    logic [31:0] lcg_state;

    pixel_shader uut (
        .clk_in          (clk_in),
        .rst_in          (rst_in),
        .tri_valid_in    (tri_valid_in),
        .v0_in           (v0_in),
        .v1_in           (v1_in),
        .v2_in           (v2_in),
        .color_valid_out (color_valid_out),
        .color_out       (color_out),
        .overflow_out    (overflow_out)
    );

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic vertex_t rand_vertex();
        logic [31:0] rx;
        logic [31:0] ry;
        logic [31:0] rz;
        rx = lcg_next();
        ry = lcg_next();
        rz = lcg_next();
        // upper lcg bits are the better ones
        return {rx[31:20], ry[31:20], rz[31:20]};
    endfunction

    // axis 2 is x, 0 is z
    function automatic longint coord_of(input vertex_t v, input int axis);
        coord_t c;
        c = v[axis*`COORD_W +: `COORD_W];
        return longint'(c);
    endfunction

    // shade index s counts table entries 1..31 that the angle has passed
    function automatic color_t ref_color(input vertex_t a, input vertex_t b, input vertex_t c);
        longint       d;
        longint       e;
        longint       f;
        longint       g;
        longint       h;
        longint       i;
        longint       nx;
        longint       ny;
        longint       nz;
        logic [127:0] lhs;
        logic [127:0] mag;
        int           s;
        d = coord_of(b, 2) - coord_of(a, 2);
        e = coord_of(b, 1) - coord_of(a, 1);
        f = coord_of(b, 0) - coord_of(a, 0);
        g = coord_of(c, 2) - coord_of(a, 2);
        h = coord_of(c, 1) - coord_of(a, 1);
        i = coord_of(c, 0) - coord_of(a, 0);
        nx = e * i - f * h;
        ny = f * g - d * i;
        nz = d * h - e * g;
        mag = 128'(nx * nx) + 128'(ny * ny) + 128'(nz * nz);
        lhs = 128'(nz * nz) << `FRAC_W;
        s = 0;
        for (int k = 1; k < 2**`TABLE_LOG2; k++) begin
            if (lhs < 128'(cos_sq_table[k]) * mag) begin
                s++;
            end
        end
        // light along -z, lit only when nz is negative
        return (nz < 0) ? color_t'(255 - 8 * s) : UNLIT_COLOR;
    endfunction

    function automatic void sync_head();
        exp_count = exp_q.size();
        exp_head  = (exp_count > 0) ? exp_q[0] : 8'h00;
    endfunction

    // drop the entry of the triangle the fifo discarded
    function automatic void drop_by_id(input int id);
        for (int k = 0; k < id_q.size(); k++) begin
            if (id_q[k] == id) begin
                id_q.delete(k);
                exp_q.delete(k);
                return;
            end
        end
        $display("overflow for triangle %0d which is not outstanding", id);
        errors++;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $finish;
    endtask

    // one triangle in the cycle after the next edge
    task automatic send_tri(input vertex_t a, input vertex_t b, input vertex_t c,
                            input color_t exp);
        @(posedge clk_in);
        #1;
        tri_valid_in = 1'b1;
        v0_in = a;
        v1_in = b;
        v2_in = c;
        cur_id = next_id;
        next_id++;
        exp_q.push_back(exp);
        id_q.push_back(cur_id);
        sync_head();
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_in);
            #1;
            tri_valid_in = 1'b0;
        end
    endtask

    task automatic send_random(input int gap);
        vertex_t a;
        vertex_t b;
        vertex_t c;
        a = rand_vertex();
        b = rand_vertex();
        c = rand_vertex();
        send_tri(a, b, c, ref_color(a, b, c));
        idle_cycles(gap);
    endtask

    // wait until every expected color has come out
    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (exp_count != 0 && waited < limit) begin
            @(posedge clk_in);
            waited++;
        end
        if (exp_count != 0) begin
            abort_run("timeout: colors still outstanding after the limit");
        end else begin
            idle_cycles(8);
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        $display("test %0d %s: %0d errors", num, name, errors - err_before);
    endtask

    // acceptance history, to find the triangle an overflow belongs to
    always @(posedge clk_in) begin
        acc_hist  <= {acc_hist[2:0], tri_valid_in && !rst_in};
        acc_id[0] <= cur_id;
        acc_id[1] <= acc_id[0];
        acc_id[2] <= acc_id[1];
        acc_id[3] <= acc_id[2];
        color_taken <= color_valid_out && !rst_in;
    end

    // scoreboard updates mid cycle, away from the edge
    // a color leaves the queue after the edge that checked it
    always @(negedge clk_in) begin
        if (!rst_in) begin
            if (color_taken) begin
                colors_rx++;
                if (exp_q.size() > 0) begin
                    void'(exp_q.pop_front());
                    void'(id_q.pop_front());
                end
            end
            if (overflow_out) begin
                ovf_seen++;
                if (!acc_hist[3]) begin
                    $display("overflow_out pulsed with no triangle 4 cycles back");
                    errors++;
                end else begin
                    drop_by_id(acc_id[3]);
                end
            end
            sync_head();
        end
    end

    a_color_expected: assert property (@(posedge clk_in) disable iff (rst_in)
        color_valid_out |-> exp_count > 0)
        else begin
            $display("color_valid_out strobed with no triangle outstanding");
            errors++;
        end

    a_color_match: assert property (@(posedge clk_in) disable iff (rst_in)
        color_valid_out && exp_count > 0 |-> color_out == exp_head)
        else begin
            $display("FAIL color_out got %h expected %h", $sampled(color_out), exp_head);
            errors++;
        end

    a_quiet: assert property (@(posedge clk_in) disable iff (rst_in)
        quiet_chk |-> !color_valid_out && !overflow_out)
        else begin
            $display("FAIL color_valid_out/overflow_out got %h/%h expected 0/0",
                     $sampled(color_valid_out), $sampled(overflow_out));
            errors++;
        end

    a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
        no_ovf_chk |-> !overflow_out)
        else begin
            $display("FAIL overflow_out got %h expected %h", $sampled(overflow_out), 1'b0);
            errors++;
        end

    initial begin
        int     err0;
        int     rx0;
        int     ovf0;
        int     sent;
        // flat triangle in the z = 0 plane
        vertex_t p0;
        vertex_t px;
        vertex_t py;
        clk_in = 1'b0;
        rst_in = 1'b1;
        tri_valid_in = 1'b0;
        v0_in = '0;
        v1_in = '0;
        v2_in = '0;
        cur_id = 0;
        next_id = 1;
        acc_hist = '0;
        color_taken = 1'b0;
        errors = 0;
        colors_rx = 0;
        ovf_seen = 0;
        quiet_chk = 1'b0;
        no_ovf_chk = 1'b0;
        lcg_state = 32'h37a4b9c2;
        sync_head();
        repeat (10) @(posedge clk_in);
        #1;
        rst_in = 1'b0;

        // nothing should come out without input
        err0 = errors;
        quiet_chk = 1'b1;
        idle_cycles(20);
        quiet_chk = 1'b0;
        report_test(1, "idle after reset", err0);

        // (0,0,0) (0,10,0) (10,0,0) gives nz = -100, straight at the light
        err0 = errors;
        p0 = {12'sd0, 12'sd0, 12'sd0};
        px = {12'sd10, 12'sd0, 12'sd0};
        py = {12'sd0, 12'sd10, 12'sd0};
        send_tri(p0, py, px, 8'hFF);
        idle_cycles(10);
        send_tri(p0, px, py, UNLIT_COLOR);
        idle_cycles(10);
        wait_drain(200);
        report_test(2, "winding", err0);

        // spaced out so the fifo never holds more than one entry
        err0 = errors;
        for (int n = 0; n < 40; n++) begin
            send_random(6 + int'(lcg_next() % 32'd5));
        end
        wait_drain(400);
        report_test(3, "random spaced", err0);

        err0 = errors;
        no_ovf_chk = 1'b1;
        for (int n = 0; n < `FIFO_DEPTH; n++) begin
            send_random(0);
        end
        idle_cycles(1);
        wait_drain(400);
        no_ovf_chk = 1'b0;
        report_test(4, "burst of fifo depth", err0);

        // three fifo depths back to back must overrun
        err0 = errors;
        rx0 = colors_rx;
        ovf0 = ovf_seen;
        sent = 3 * `FIFO_DEPTH;
        for (int n = 0; n < sent; n++) begin
            send_random(0);
        end
        idle_cycles(1);
        wait_drain(800);
        assert (ovf_seen > ovf0)
        else begin
            $display("no overflow_out pulse during a burst of %0d triangles", sent);
            errors++;
        end
        assert (colors_rx - rx0 == sent - (ovf_seen - ovf0))
        else begin
            $display("FAIL colors_received got %h expected %h",
                     colors_rx - rx0, sent - (ovf_seen - ovf0));
            errors++;
        end
        report_test(5, "overrun burst", err0);

        $display("tests 5, colors %0d, overflows %0d, errors %0d",
                 colors_rx, ovf_seen, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/pixel_shader.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_shader (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    tri_valid_in,
    input  wire geom_pkg::vertex_t v0_in,
    input  wire geom_pkg::vertex_t v1_in,
    input  wire geom_pkg::vertex_t v2_in,
    output logic                   color_valid_out,
    output shade_pkg::color_t      color_out,
    output logic                   overflow_out
);
    import geom_pkg::*;

    // pipeline to fifo
    logic    res_valid;
    sq_t     nz_sq;
    mag_sq_t mag_sq;
    logic    facing;

    // fifo head to lookup
    sq_t     head_nz_sq;
    mag_sq_t head_mag_sq;
    logic    head_facing;
    logic    empty;
    logic    pop;

    // one triangle per cycle in, fixed 4 cycle latency
    normal_pipeline u_pipe (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .tri_valid_in (tri_valid_in),
        .v0_in        (v0_in),
        .v1_in        (v1_in),
        .v2_in        (v2_in),
        .res_valid    (res_valid),
        .nz_sq        (nz_sq),
        .mag_sq       (mag_sq),
        .facing       (facing)
    );

    // absorbs bursts, the lookup needs 6 cycles per entry
    normal_fifo u_fifo (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .wr          (res_valid),
        .wr_nz_sq    (nz_sq),
        .wr_mag_sq   (mag_sq),
        .wr_facing   (facing),
        .pop         (pop),
        .head_nz_sq  (head_nz_sq),
        .head_mag_sq (head_mag_sq),
        .head_facing (head_facing),
        .empty       (empty),
        .overflow    (overflow_out)
    );

    shade_lookup u_lookup (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .empty       (empty),
        .head_nz_sq  (head_nz_sq),
        .head_mag_sq (head_mag_sq),
        .head_facing (head_facing),
        .pop         (pop),
        .color_valid (color_valid_out),
        .color       (color_out)
    );

endmodule

`default_nettype wire

// File: verilog/shade_lookup.sv
`timescale 1ns/1ps
`default_nettype none
`include "shader_settings.svh"

module shade_lookup (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    empty,
    input  wire geom_pkg::sq_t     head_nz_sq,
    input  wire geom_pkg::mag_sq_t head_mag_sq,
    input  wire                    head_facing,
    output logic                   pop,
    output logic                   color_valid,
    output shade_pkg::color_t      color
);
    import geom_pkg::*;
    import shade_pkg::*;

    // width of threshold times |n|^2
    localparam int PROD_W = $bits(mag_sq_t) + $bits(thresh_t);
    // first probe is the middle of the table
    localparam shade_idx_t FIRST_BIT = shade_idx_t'(1) << (`TABLE_LOG2 - 1);

    search_state_t state;

    // latched fifo head
    sq_t     nz_sq_r;
    mag_sq_t mag_sq_r;
    logic    facing_r;

    // s is built one bit per step, msb first
    shade_idx_t s_r;
    shade_idx_t bit_r;
    shade_idx_t cand;
    shade_idx_t s_next;

    logic [PROD_W-1:0] lhs;
    logic [PROD_W-1:0] rhs;
    logic              hit;

    // new entry when idle, or straight after an output
    assign pop = !empty && (state == IDLE || state == EMIT);

    // probe entry cand
    // nz^2 * 2^16 < T[cand] * |n|^2 means the angle is past entry cand
    // table decreasing, so the hits form a prefix 1..s
    always_comb begin
        cand   = s_r | bit_r;
        lhs    = {nz_sq_r, {`FRAC_W{1'b0}}};
        rhs    = cos_sq_table[cand] * mag_sq_r;
        hit    = lhs < rhs;
        s_next = hit ? cand : s_r;
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state       <= IDLE;
            s_r         <= '0;
            bit_r       <= '0;
            color_valid <= 1'b0;
        end else begin
            color_valid <= 1'b0;
            case (state)
                IDLE, EMIT: begin
                    if (pop) begin
                        s_r   <= '0;
                        bit_r <= FIRST_BIT;
                        state <= SEARCH;
                    end else begin
                        state <= IDLE;
                    end
                end
                SEARCH: begin
                    s_r   <= s_next;
                    bit_r <= bit_r >> 1;
                    // lsb probed, s complete
                    if (bit_r[0]) begin
                        state       <= EMIT;
                        color_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // payload side
    always_ff @(posedge clk_in) begin
        if (pop) begin
            nz_sq_r  <= head_nz_sq;
            mag_sq_r <= head_mag_sq;
            facing_r <= head_facing;
        end
        // grey = 255 - 8*s, dark when facing away
        if (state == SEARCH && bit_r[0]) begin
            color <= facing_r ? FULL_COLOR - (color_t'(s_next) << SHADE_SHIFT) : UNLIT_COLOR;
        end
    end

    a_valid_in_emit: assert property (@(posedge clk_in) disable iff (rst_in)
        color_valid |-> state == EMIT)
        else $error("color_valid outside EMIT");

    // Every pop yields exactly one color after the full search.
    a_pop_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        pop |-> ##(`TABLE_LOG2 + 1) color_valid)
        else $error("color_valid missing after pop");

endmodule

`default_nettype wire

// File: verilog/normal_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "shader_settings.svh"

module normal_fifo (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    wr,
    input  wire geom_pkg::sq_t     wr_nz_sq,
    input  wire geom_pkg::mag_sq_t wr_mag_sq,
    input  wire                    wr_facing,
    input  wire                    pop,
    output geom_pkg::sq_t          head_nz_sq,
    output geom_pkg::mag_sq_t      head_mag_sq,
    output logic                   head_facing,
    output logic                   empty,
    output logic                   overflow
);
    import geom_pkg::*;

    localparam int DEPTH = `FIFO_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // one entry per pipeline result
    sq_t     nz_mem   [DEPTH];
    mag_sq_t mag_mem  [DEPTH];
    logic    face_mem [DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             do_wr;
    logic             do_rd;

    // wrap at DEPTH, also for non power of two depths
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);
    assign do_wr = wr && !full;
    assign do_rd = pop && !empty;

    // result arriving on a full fifo is lost
    assign overflow = wr && full;

    // head is read straight out of storage
    assign head_nz_sq  = nz_mem[rd_ptr];
    assign head_mag_sq = mag_mem[rd_ptr];
    assign head_facing = face_mem[rd_ptr];

    always_ff @(posedge clk_in) begin
        if (do_wr) begin
            nz_mem[wr_ptr]   <= wr_nz_sq;
            mag_mem[wr_ptr]  <= wr_mag_sq;
            face_mem[wr_ptr] <= wr_facing;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            // simultaneous push and pop keeps the count
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the lookup must only pop a valid head
    a_pop_not_empty: assert property (@(posedge clk_in) disable iff (rst_in)
        pop |-> !empty)
        else $error("pop while fifo empty");

    a_count_bound: assert property (@(posedge clk_in) disable iff (rst_in)
        count <= CNT_W'(DEPTH))
        else $error("fifo count %0d above depth %0d", count, DEPTH);

endmodule

`default_nettype wire

// File: verilog/normal_pipeline.sv
`timescale 1ns/1ps
`default_nettype none
`include "shader_settings.svh"

module normal_pipeline (
    input  wire                    clk_in,
    input  wire                    rst_in,
    input  wire                    tri_valid_in,
    input  wire geom_pkg::vertex_t v0_in,
    input  wire geom_pkg::vertex_t v1_in,
    input  wire geom_pkg::vertex_t v2_in,
    output logic                   res_valid,
    output geom_pkg::sq_t          nz_sq,
    output geom_pkg::mag_sq_t      mag_sq,
    output logic                   facing
);
    import geom_pkg::*;

    localparam int PIPE_DEPTH = 4;
    // slot of each axis inside a packed vertex
    localparam int AX_X = 2;
    localparam int AX_Y = 1;
    localparam int AX_Z = 0;

    // u = v1 - v0 = (d, e, f), v = v2 - v0 = (g, h, i)
    edge_t s1_d;
    edge_t s1_e;
    edge_t s1_f;
    edge_t s1_g;
    edge_t s1_h;
    edge_t s1_i;

    normal_comp_t s2_ei;
    normal_comp_t s2_fh;
    normal_comp_t s2_fg;
    normal_comp_t s2_di;
    normal_comp_t s2_dh;
    normal_comp_t s2_eg;

    normal_comp_t s3_nx;
    normal_comp_t s3_ny;
    normal_comp_t s3_nz;

    sq_t sq_x;
    sq_t sq_y;
    sq_t sq_z;

    logic [PIPE_DEPTH-1:0] vld_sr;

    // one axis of a - b, sign extended before subtracting
    function automatic edge_t sub_axis(input vertex_t a, input vertex_t b, input int axis);
        coord_t ca;
        coord_t cb;
        ca = a[axis*`COORD_W +: `COORD_W];
        cb = b[axis*`COORD_W +: `COORD_W];
        return edge_t'(ca) - edge_t'(cb);
    endfunction

    // stage 1, edge vectors
    always_ff @(posedge clk_in) begin
        s1_d <= sub_axis(v1_in, v0_in, AX_X);
        s1_e <= sub_axis(v1_in, v0_in, AX_Y);
        s1_f <= sub_axis(v1_in, v0_in, AX_Z);
        s1_g <= sub_axis(v2_in, v0_in, AX_X);
        s1_h <= sub_axis(v2_in, v0_in, AX_Y);
        s1_i <= sub_axis(v2_in, v0_in, AX_Z);
    end

    // stage 2, the six partial products of u x v
    always_ff @(posedge clk_in) begin
        s2_ei <= s1_e * s1_i;
        s2_fh <= s1_f * s1_h;
        s2_fg <= s1_f * s1_g;
        s2_di <= s1_d * s1_i;
        s2_dh <= s1_d * s1_h;
        s2_eg <= s1_e * s1_g;
    end

    // stage 3, normal = (ei - fh, fg - di, dh - eg)
    always_ff @(posedge clk_in) begin
        s3_nx <= s2_ei - s2_fh;
        s3_ny <= s2_fg - s2_di;
        s3_nz <= s2_dh - s2_eg;
    end

    // squares, signed operands so the product is exact
    always_comb begin
        sq_x = s3_nx * s3_nx;
        sq_y = s3_ny * s3_ny;
        sq_z = s3_nz * s3_nz;
    end

    // stage 4
    // light is (0, 0, -1), so the face is lit when nz < 0
    always_ff @(posedge clk_in) begin
        mag_sq <= sq_x + sq_y + sq_z;
        nz_sq  <= sq_z;
        facing <= s3_nz[$bits(normal_comp_t)-1];
    end

    // valid bits ride along with the data
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            vld_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[PIPE_DEPTH-2:0], tri_valid_in};
        end
    end

    assign res_valid = vld_sr[PIPE_DEPTH-1];

    // fixed latency, one result per accepted triangle
    a_res_latency: assert property (@(posedge clk_in) disable iff (rst_in)
        tri_valid_in |-> ##PIPE_DEPTH res_valid)
        else $error("res_valid missing %0d cycles after tri_valid_in", PIPE_DEPTH);

    a_res_origin: assert property (@(posedge clk_in) disable iff (rst_in)
        res_valid |-> $past(tri_valid_in, PIPE_DEPTH))
        else $error("res_valid without a triangle %0d cycles earlier", PIPE_DEPTH);

endmodule

`default_nettype wire

// File: verilog/shade_pkg.sv
`default_nettype none
`include "shader_settings.svh"

package shade_pkg;

    typedef logic [7:0]             color_t;
    typedef logic [`TABLE_LOG2-1:0] shade_idx_t;
    // one integer bit so that 1.0 fits
    typedef logic [`FRAC_W:0]       thresh_t;

    // lookup fsm
    typedef enum logic [1:0] {
        IDLE,
        SEARCH,
        EMIT
    } search_state_t;

    // back-facing triangles
    localparam color_t UNLIT_COLOR = 8'h00;
    // brightest level, normal pointing straight at the light
    localparam color_t FULL_COLOR  = 8'hFF;
    // each table step darkens by 8 levels
    localparam int     SHADE_SHIFT = 3;

    // cos^2 of k * 90/32 degrees, scaled by 2^16
    // strictly decreasing
    localparam thresh_t cos_sq_table [2**`TABLE_LOG2] = '{
        17'd65536,
        17'd65378,
        17'd64906,
        17'd64125,
        17'd63042,
        17'd61667,
        17'd60014,
        17'd58098,
        // 22.5 deg
        17'd55938,
        17'd53556,
        17'd50973,
        17'd48215,
        17'd45308,
        17'd42280,
        17'd39161,
        17'd35980,
        // 45 deg, exactly one half
        17'd32768,
        17'd29556,
        17'd26375,
        17'd23256,
        17'd20228,
        17'd17321,
        17'd14563,
        17'd11980,
        // 67.5 deg
        17'd9598,
        17'd7438,
        17'd5522,
        17'd3869,
        17'd2494,
        17'd1411,
        17'd630,
        17'd158
    };

endpackage

`default_nettype wire

// File: verilog/geom_pkg.sv
`default_nettype none
`include "shader_settings.svh"

package geom_pkg;

    // edge = difference of two coords, one extra bit
    localparam int EDGE_W   = `COORD_W + 1;
    // cross product term plus one bit for the subtraction
    localparam int NORMAL_W = 2 * EDGE_W + 1;
    // square of one normal component
    localparam int SQ_W     = 2 * NORMAL_W;
    // sum of three squares needs two more bits
    localparam int MAG_W    = SQ_W + 2;

    typedef logic signed [`COORD_W-1:0] coord_t;

    // packed as {x, y, z}, x in the top bits
    typedef logic [3*`COORD_W-1:0] vertex_t;

    typedef logic signed [EDGE_W-1:0]   edge_t;
    typedef logic signed [NORMAL_W-1:0] normal_comp_t;

    // squares are never negative
    typedef logic [SQ_W-1:0]  sq_t;
    typedef logic [MAG_W-1:0] mag_sq_t;

endpackage

`default_nettype wire

// File: include/shader_settings.svh
`ifndef SHADER_SETTINGS_SVH
`define SHADER_SETTINGS_SVH

// bits per signed vertex coordinate
`define COORD_W 12

// entries in the normal result fifo
`define FIFO_DEPTH 8

// log2 of the cos^2 threshold table size
// also the number of search steps
`define TABLE_LOG2 5

// fraction bits of each threshold
// 1.0 is 2^FRAC_W
`define FRAC_W 16

`endif
